// File: cpl_router.sv
//--------------------------------------------------------------------------
// Result stage: completion tag lookup, routing to the owning DMA port,
// tag release on the last completion, unexpected-completion flag
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module cpl_router import pcie_trans_pkg::*; #(
    parameter int DMA_PORTS = 2
) (
    input  wire logic                 clk,
    input  wire logic                 rst,

    input  wire logic                 rc_src_rdy,
    input  wire rc_hdr_t              rc_hdr,
    output logic                      rc_dst_rdy,

    tag_lookup_if.res                 lookup,

    output logic [DMA_PORTS-1:0]      down_src_rdy,
    output down_hdr_t                 down_hdr,
    input  wire logic [DMA_PORTS-1:0] down_dst_rdy,

    output logic                      unexp_cpl
);

    logic rc_fire;
    logic down_drain;

    // Held completion leaves this cycle
    assign down_drain = |(down_src_rdy & down_dst_rdy);
    assign rc_dst_rdy = !(|down_src_rdy) || down_drain;
    assign rc_fire    = rc_src_rdy && rc_dst_rdy;

    // Lookup and release
    assign lookup.lookup_tag  = rc_hdr.pcie_tag;
    assign lookup.release_vld = rc_fire && lookup.hit && rc_hdr.last;
    assign lookup.release_tag = rc_hdr.pcie_tag;

    // ----------------------------------------------------------------------
    // Output register, one-hot on the owner port
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            down_src_rdy <= '0;
        end else if (rc_fire && lookup.hit) begin
            down_src_rdy <= DMA_PORTS'(1) << lookup.owner_port;
        end else if (down_drain) begin
            down_src_rdy <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rc_fire && lookup.hit) begin
            down_hdr.dma_tag <= lookup.owner_dma_tag;
            down_hdr.len     <= rc_hdr.len;
            down_hdr.last    <= rc_hdr.last;
        end
    end

    // Miss is swallowed and flagged for one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            unexp_cpl <= 1'b0;
        end else begin
            unexp_cpl <= rc_fire && !lookup.hit;
        end
    end

endmodule

`default_nettype wire

// File: pcie_trans_ctrl.sv
//--------------------------------------------------------------------------
// Top level of the PCIe transaction controller core: decode, execute
// and result stages joined by the internal channels
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module pcie_trans_ctrl import pcie_trans_pkg::*; #(
    parameter int DMA_PORTS = 2,
    parameter int PCIE_TAGS = 4
) (
    input  wire logic                 clk,
    input  wire logic                 rst,

    // Upstream from DMA ports
    input  wire logic [DMA_PORTS-1:0] up_src_rdy,
    input  wire up_hdr_t              up_hdr [DMA_PORTS],
    output logic [DMA_PORTS-1:0]      up_dst_rdy,

    // Requests to the endpoint
    output logic                      rq_src_rdy,
    output rq_hdr_t                   rq_hdr,
    input  wire logic                 rq_dst_rdy,

    // Completions from the endpoint
    input  wire logic                 rc_src_rdy,
    input  wire rc_hdr_t              rc_hdr,
    output logic                      rc_dst_rdy,

    // Downstream to DMA ports
    output logic [DMA_PORTS-1:0]      down_src_rdy,
    output down_hdr_t                 down_hdr,
    input  wire logic [DMA_PORTS-1:0] down_dst_rdy,

    output logic                      unexp_cpl
);

    dec_req_if    #(.DMA_PORTS(DMA_PORTS)) dec_req ();
    tag_lookup_if #(.DMA_PORTS(DMA_PORTS)) tag_lookup ();

    up_hdr_decode #(
        .DMA_PORTS (DMA_PORTS)
    ) u_decode (
        .clk        (clk),
        .rst        (rst),
        .up_src_rdy (up_src_rdy),
        .up_hdr     (up_hdr),
        .up_dst_rdy (up_dst_rdy),
        .req        (dec_req)
    );

    tag_manager #(
        .DMA_PORTS (DMA_PORTS),
        .PCIE_TAGS (PCIE_TAGS)
    ) u_tag_mgr (
        .clk        (clk),
        .rst        (rst),
        .req        (dec_req),
        .lookup     (tag_lookup),
        .rq_src_rdy (rq_src_rdy),
        .rq_hdr     (rq_hdr),
        .rq_dst_rdy (rq_dst_rdy)
    );

    cpl_router #(
        .DMA_PORTS (DMA_PORTS)
    ) u_cpl_router (
        .clk          (clk),
        .rst          (rst),
        .rc_src_rdy   (rc_src_rdy),
        .rc_hdr       (rc_hdr),
        .rc_dst_rdy   (rc_dst_rdy),
        .lookup       (tag_lookup),
        .down_src_rdy (down_src_rdy),
        .down_hdr     (down_hdr),
        .down_dst_rdy (down_dst_rdy),
        .unexp_cpl    (unexp_cpl)
    );

endmodule

`default_nettype wire

// File: pcie_trans_pkg.sv
//--------------------------------------------------------------------------
// Shared definitions of the PCIe transaction controller core: width
// constants, DMA and TLP opcode enums, and the request and completion
// header structs for the DMA and PCIe sides
//--------------------------------------------------------------------------

`default_nettype none

package pcie_trans_pkg;

    // Field widths
    localparam int LEN_W  = 11;
    localparam int ADDR_W = 32;
    localparam int TAG_W  = 8;

    // DMA request kind
    typedef enum logic {
        DMA_READ  = 1'b0,
        DMA_WRITE = 1'b1
    } dma_op_e;

    // PCIe request type
    typedef enum logic {
        TLP_MRD = 1'b0,
        TLP_MWR = 1'b1
    } tlp_type_e;

    // Request header from a DMA port
    typedef struct packed {
        dma_op_e             op;
        logic [LEN_W-1:0]    len;
        logic [ADDR_W-1:0]   addr;
        logic [TAG_W-1:0]    dma_tag;
    } up_hdr_t;

    // Request header towards the endpoint
    typedef struct packed {
        tlp_type_e           tlp_type;
        logic [LEN_W-1:0]    len;
        logic [ADDR_W-1:0]   addr;
        logic [TAG_W-1:0]    pcie_tag;
    } rq_hdr_t;

    // Completion header from the endpoint
    typedef struct packed {
        logic [TAG_W-1:0]    pcie_tag;
        logic [LEN_W-1:0]    len;
        logic                last;
    } rc_hdr_t;

    // Completion header towards a DMA port
    typedef struct packed {
        logic [TAG_W-1:0]    dma_tag;
        logic [LEN_W-1:0]    len;
        logic                last;
    } down_hdr_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing -f sim.f --top-module tb_pcie_trans_ctrl -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
echo "Simulation run succeeded" ||
{ echo "Simulation run failed"; exit 1; }

// File: sim.f
pcie_trans_pkg.sv
trans_ifs.sv
up_hdr_decode.sv
tag_manager.sv
cpl_router.sv
pcie_trans_ctrl.sv
tb_pcie_trans_ctrl.sv

// File: tag_manager.sv
//--------------------------------------------------------------------------
// Execute stage: PCIe tag table with lowest-free allocation, release on
// last completion, combinational lookup, and the registered request
// header towards the endpoint
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tag_manager import pcie_trans_pkg::*; #(
    parameter int DMA_PORTS = 2,
    parameter int PCIE_TAGS = 4
) (
    input  wire logic  clk,
    input  wire logic  rst,

    dec_req_if.exe     req,
    tag_lookup_if.exe  lookup,

    output logic       rq_src_rdy,
    output rq_hdr_t    rq_hdr,
    input  wire logic  rq_dst_rdy
);

    localparam int PORT_W = (DMA_PORTS > 1) ? $clog2(DMA_PORTS) : 1;
    localparam int TIDX_W = (PCIE_TAGS > 1) ? $clog2(PCIE_TAGS) : 1;

    // ----------------------------------------------------------------------
    // Tag table
    // ----------------------------------------------------------------------
    logic [PCIE_TAGS-1:0] busy;
    logic [PORT_W-1:0]    owner_tab   [PCIE_TAGS];
    logic [TAG_W-1:0]     dma_tag_tab [PCIE_TAGS];

    logic                 free_found;
    logic [TIDX_W-1:0]    free_idx;

    logic                 is_read;
    logic                 out_free;
    logic                 dec_fire;
    logic                 alloc;

    logic [TIDX_W-1:0]    lk_idx;
    logic [TIDX_W-1:0]    rel_idx;

    // Lowest free entry, scanning downwards so the last match wins
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = PCIE_TAGS - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_found = 1'b1;
                free_idx   = TIDX_W'(i);
            end
        end
    end

    assign is_read  = (req.hdr.op == DMA_READ);
    assign out_free = !rq_src_rdy || rq_dst_rdy;

    // A read waits here until some tag is free
    assign req.dst_rdy = out_free && (!is_read || free_found);
    assign dec_fire    = req.src_rdy && req.dst_rdy;
    assign alloc       = dec_fire && is_read;

    assign rel_idx = lookup.release_tag[TIDX_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            // Release and allocation never hit the same entry
            if (lookup.release_vld) begin
                busy[rel_idx] <= 1'b0;
            end
            if (alloc) begin
                busy[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            owner_tab[free_idx]   <= req.port;
            dma_tag_tab[free_idx] <= req.hdr.dma_tag;
        end
    end

    // ----------------------------------------------------------------------
    // Completion lookup
    // ----------------------------------------------------------------------
    assign lk_idx = lookup.lookup_tag[TIDX_W-1:0];

    // Tags beyond the table size are never busy
    assign lookup.hit           = (int'(lookup.lookup_tag) < PCIE_TAGS) && busy[lk_idx];
    assign lookup.owner_port    = owner_tab[lk_idx];
    assign lookup.owner_dma_tag = dma_tag_tab[lk_idx];

    // ----------------------------------------------------------------------
    // Outgoing request register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rq_src_rdy <= 1'b0;
        end else if (dec_fire) begin
            rq_src_rdy <= 1'b1;
        end else if (rq_dst_rdy) begin
            rq_src_rdy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_fire) begin
            rq_hdr.len  <= req.hdr.len;
            rq_hdr.addr <= req.hdr.addr;
            if (is_read) begin
                rq_hdr.tlp_type <= TLP_MRD;
                rq_hdr.pcie_tag <= TAG_W'(free_idx);
            end else begin
                // Writes are posted and take no tag
                rq_hdr.tlp_type <= TLP_MWR;
                rq_hdr.pcie_tag <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_pcie_trans_ctrl.sv
//--------------------------------------------------------------------------
// Directed testbench for the PCIe transaction controller core: stimulus
// tasks, tag table model, compare tasks, bus monitor and watchdog
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_pcie_trans_ctrl import pcie_trans_pkg::*; ();

    localparam int DMA_PORTS = 2;
    localparam int PCIE_TAGS = 4;
    localparam int PORT_W    = 1;
    localparam int PERIOD    = 40;
    localparam int SETTLE    = 5;
    localparam int HS_LIMIT  = 50;
    localparam int NUM_TESTS = 6;

    typedef logic [PORT_W-1:0] port_t;

    logic                 clk;
    logic                 rst;
    logic [DMA_PORTS-1:0] up_src_rdy;
    up_hdr_t              up_hdr [DMA_PORTS];
    logic [DMA_PORTS-1:0] up_dst_rdy;
    logic                 rq_src_rdy;
    rq_hdr_t              rq_hdr;
    logic                 rq_dst_rdy;
    logic                 rc_src_rdy;
    rc_hdr_t              rc_hdr;
    logic                 rc_dst_rdy;
    logic [DMA_PORTS-1:0] down_src_rdy;
    down_hdr_t            down_hdr;
    logic [DMA_PORTS-1:0] down_dst_rdy;
    logic                 unexp_cpl;

    int          mismatches   = 0;
    int          other_errors = 0;
    int          flag_cnt     = 0;
    int unsigned seed         = 1;

    // Headers seen on the output channels, in transfer order
    rq_hdr_t   rq_q [$];
    down_hdr_t down_q [$];
    port_t     down_port_q [$];

    // Tag table model
    logic             m_busy  [PCIE_TAGS];
    port_t            m_owner [PCIE_TAGS];
    logic [TAG_W-1:0] m_dma   [PCIE_TAGS];

    pcie_trans_ctrl #(.DMA_PORTS(DMA_PORTS), .PCIE_TAGS(PCIE_TAGS)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * 200 * PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Stimulus helpers and the tag table model
    // ----------------------------------------------------------------------
    function automatic int unsigned lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic up_hdr_t make_hdr(input dma_op_e op, input int dt);
        up_hdr_t h;
        h.op      = op;
        h.len     = LEN_W'((lcg_next() >> 16) % 512 + 1);
        h.addr    = ADDR_W'(lcg_next() & 32'hffff_fffc);
        h.dma_tag = TAG_W'(dt);
        return h;
    endfunction

    function automatic rc_hdr_t make_rc(input int tag, input logic last);
        rc_hdr_t c;
        c.pcie_tag = TAG_W'(tag);
        c.len      = LEN_W'((lcg_next() >> 16) % 64 + 1);
        c.last     = last;
        return c;
    endfunction

    // Lowest free tag, as the endpoint should see it
    function automatic int model_alloc(input port_t p, input logic [TAG_W-1:0] dt);
        for (int i = 0; i < PCIE_TAGS; i++) begin
            if (!m_busy[i]) begin
                m_busy[i]  = 1'b1;
                m_owner[i] = p;
                m_dma[i]   = dt;
                return i;
            end
        end
        return -1;
    endfunction

    task automatic do_reset();
        rst          = 1'b1;
        up_src_rdy   = '0;
        rc_src_rdy   = 1'b0;
        rc_hdr       = '0;
        rq_dst_rdy   = 1'b1;
        down_dst_rdy = '1;
        for (int i = 0; i < DMA_PORTS; i++) up_hdr[i] = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        rq_q.delete();
        down_q.delete();
        down_port_q.delete();
        flag_cnt = 0;
        for (int i = 0; i < PCIE_TAGS; i++) m_busy[i] = 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------
    task automatic check_rq(input rq_hdr_t got, input rq_hdr_t exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s: type %0d tag %0d len %0d addr %h,",
                     $time, what, got.tlp_type, got.pcie_tag, got.len, got.addr,
                     " expected type %0d tag %0d len %0d addr %h",
                     exp.tlp_type, exp.pcie_tag, exp.len, exp.addr);
        end
    endtask

    task automatic check_down(input down_hdr_t got, input port_t got_port,
                              input down_hdr_t exp, input port_t exp_port, input string what);
        if (got !== exp || got_port !== exp_port) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s: port %0d dma_tag %h len %0d last %b,",
                     $time, what, got_port, got.dma_tag, got.len, got.last,
                     " expected port %0d dma_tag %h len %0d last %b",
                     exp_port, exp.dma_tag, exp.len, exp.last);
        end
    endtask

    task automatic check_flag(input int got, input int exp, input string what);
        if (got != exp) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s: %0d unexp_cpl pulses, expected %0d",
                     $time, what, got, exp);
        end
    endtask

    // ----------------------------------------------------------------------
    // Monitor, sampling mid-cycle after the falling-edge drive
    // ----------------------------------------------------------------------
    logic      rq_held;
    rq_hdr_t   rq_last;
    logic      down_held;
    down_hdr_t down_last;
    port_t     down_last_port;

    always begin
        port_t dp;
        @(negedge clk);
        #SETTLE;
        dp = '0;
        for (int p = 0; p < DMA_PORTS; p++) if (down_src_rdy[p]) dp = port_t'(p);
        if (rst) begin
            rq_held   = 1'b0;
            down_held = 1'b0;
        end else begin
            if ((rq_held && !rq_src_rdy) || (down_held && down_src_rdy == '0)) begin
                other_errors++;
                $display("A held header was withdrawn at %0t ns before it was taken", $time);
            end
            if (rq_held) check_rq(rq_hdr, rq_last, "held request changed");
            if (down_held) check_down(down_hdr, dp, down_last, down_last_port, "held completion");
            if ($countones(down_src_rdy) > 1) begin
                mismatches++;
                $display("Mismatch at %0t ns: down_src_rdy %b is not one-hot", $time, down_src_rdy);
            end
            if (rq_src_rdy && rq_dst_rdy) rq_q.push_back(rq_hdr);
            if ((down_src_rdy & down_dst_rdy) != '0) begin
                down_q.push_back(down_hdr);
                down_port_q.push_back(dp);
            end
            if (unexp_cpl) flag_cnt++;
            rq_held        = rq_src_rdy && !rq_dst_rdy;
            rq_last        = rq_hdr;
            down_held      = (down_src_rdy & ~down_dst_rdy) != '0;
            down_last      = down_hdr;
            down_last_port = dp;
        end
    end

    // ----------------------------------------------------------------------
    // Channel drivers and waits, all starting and ending on a falling edge
    // ----------------------------------------------------------------------
    task automatic send_up(input int p, input up_hdr_t h);
        int   n;
        logic acc;
        n             = 0;
        acc           = 1'b0;
        up_hdr[p]     = h;
        up_src_rdy[p] = 1'b1;
        while (!acc && n < HS_LIMIT) begin
            #SETTLE;
            acc = up_dst_rdy[p];
            @(negedge clk);
            n++;
        end
        up_src_rdy[p] = 1'b0;
        if (!acc) begin
            other_errors++;
            $display("Request on DMA port %0d was never accepted", p);
        end
    endtask

    task automatic send_rc(input rc_hdr_t c);
        int   n;
        logic acc;
        n          = 0;
        acc        = 1'b0;
        rc_hdr     = c;
        rc_src_rdy = 1'b1;
        while (!acc && n < HS_LIMIT) begin
            #SETTLE;
            acc = rc_dst_rdy;
            @(negedge clk);
            n++;
        end
        rc_src_rdy = 1'b0;
        if (!acc) begin
            other_errors++;
            $display("Completion with tag %0d was never accepted", c.pcie_tag);
        end
    endtask

    task automatic expect_rq(input int p, input up_hdr_t sent, input string what);
        rq_hdr_t exp;
        int      n;
        n = 0;
        while (rq_q.size() == 0 && n < HS_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (rq_q.size() == 0) begin
            other_errors++;
            $display("No request header reached the endpoint for the %s", what);
        end else begin
            exp.len  = sent.len;
            exp.addr = sent.addr;
            if (sent.op == DMA_READ) begin
                exp.tlp_type = TLP_MRD;
                exp.pcie_tag = TAG_W'(model_alloc(port_t'(p), sent.dma_tag));
            end else begin
                exp.tlp_type = TLP_MWR;
                exp.pcie_tag = '0;
            end
            check_rq(rq_q.pop_front(), exp, what);
        end
    endtask

    // Forwarded completion for a busy tag; a free tag is left to the caller
    task automatic expect_cpl(input rc_hdr_t c, input string what);
        down_hdr_t exp;
        int        t;
        int        n;
        t = int'(c.pcie_tag);
        n = 0;
        if (t < PCIE_TAGS && m_busy[t]) begin
            exp.dma_tag = m_dma[t];
            exp.len     = c.len;
            exp.last    = c.last;
            while (down_q.size() == 0 && n < HS_LIMIT) begin
                @(negedge clk);
                n++;
            end
            if (down_q.size() == 0) begin
                other_errors++;
                $display("No completion reached a DMA port for the %s", what);
            end else begin
                check_down(down_q.pop_front(), down_port_q.pop_front(), exp, m_owner[t], what);
            end
            if (c.last) m_busy[t] = 1'b0;
        end
    endtask

    task automatic check_idle();
        repeat (4) @(negedge clk);
        if (rq_q.size() != 0 || down_q.size() != 0) begin
            other_errors++;
            $display("Extra headers seen: %0d requests and %0d completions",
                     rq_q.size(), down_q.size());
        end
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------
    task automatic test_reads_writes();
        up_hdr_t h;
        do_reset();
        for (int i = 0; i < 3; i++) begin
            h = make_hdr(DMA_READ, 16 + i);
            send_up(0, h);
            expect_rq(0, h, "read from port 0");
        end
        h = make_hdr(DMA_WRITE, 0);
        send_up(0, h);
        expect_rq(0, h, "write from port 0");
        // Table untouched by the write, next read takes tag 3
        h = make_hdr(DMA_READ, 19);
        send_up(0, h);
        expect_rq(0, h, "read after the write");
        check_idle();
    endtask

    task automatic test_exhaustion();
        up_hdr_t h;
        rc_hdr_t c;
        do_reset();
        for (int i = 0; i < PCIE_TAGS; i++) begin
            h = make_hdr(DMA_READ, i);
            send_up(0, h);
            expect_rq(0, h, "read filling the tag table");
        end
        h = make_hdr(DMA_READ, 4);
        send_up(0, h);
        repeat (10) @(negedge clk);
        if (rq_q.size() != 0 || rq_src_rdy) begin
            mismatches++;
            $display("Mismatch at %0t ns: read issued while every tag was busy", $time);
        end
        c = make_rc(1, 1'b1);
        send_rc(c);
        expect_cpl(c, "completion freeing tag 1");
        expect_rq(0, h, "read waiting for a free tag");
        check_idle();
    endtask

    task automatic test_routing();
        up_hdr_t h;
        rc_hdr_t c;
        do_reset();
        h = make_hdr(DMA_READ, 8'h11);
        send_up(0, h);
        expect_rq(0, h, "read from port 0");
        h = make_hdr(DMA_READ, 8'h22);
        send_up(1, h);
        expect_rq(1, h, "read from port 1");
        c = make_rc(1, 1'b0);
        send_rc(c);
        expect_cpl(c, "partial completion to port 1");
        // Tag 1 still busy, so this read takes tag 2
        h = make_hdr(DMA_READ, 8'h33);
        send_up(0, h);
        expect_rq(0, h, "read during a partial completion");
        c = make_rc(1, 1'b1);
        send_rc(c);
        expect_cpl(c, "last completion to port 1");
        c = make_rc(0, 1'b1);
        send_rc(c);
        expect_cpl(c, "completion of tag 0 to port 0");
        c = make_rc(2, 1'b1);
        send_rc(c);
        expect_cpl(c, "completion of tag 2 to port 0");
        check_idle();
    endtask

    task automatic test_round_robin();
        up_hdr_t h0 [3];
        up_hdr_t h1 [3];
        do_reset();
        for (int i = 0; i < 3; i++) begin
            h0[i] = make_hdr(DMA_WRITE, i);
            h1[i] = make_hdr(DMA_WRITE, 8 + i);
        end
        fork
            for (int i = 0; i < 3; i++) send_up(0, h0[i]);
            for (int i = 0; i < 3; i++) send_up(1, h1[i]);
        join
        for (int i = 0; i < 3; i++) begin
            expect_rq(0, h0[i], "round-robin turn of port 0");
            expect_rq(1, h1[i], "round-robin turn of port 1");
        end
        check_idle();
    endtask

    task automatic test_unexpected();
        up_hdr_t h;
        do_reset();
        // Tag 0 busy, so a tag that aliases it in the low bits must still miss
        h = make_hdr(DMA_READ, 8'h44);
        send_up(0, h);
        expect_rq(0, h, "read holding tag 0");
        send_rc(make_rc(2, 1'b1));
        repeat (4) @(negedge clk);
        check_flag(flag_cnt, 1, "completion with free tag 2");
        send_rc(make_rc(4, 1'b0));
        repeat (4) @(negedge clk);
        check_flag(flag_cnt, 2, "completion with tag 4 beyond the table");
        check_idle();
    endtask

    task automatic test_backpressure();
        up_hdr_t h [3];
        rc_hdr_t c [2];
        do_reset();
        for (int i = 0; i < 3; i++) h[i] = make_hdr(DMA_WRITE, i);
        fork
            for (int i = 0; i < 3; i++) send_up(0, h[i]);
            begin
                rq_dst_rdy = 1'b0;
                repeat (12) @(negedge clk);
                rq_dst_rdy = 1'b1;
            end
        join
        for (int i = 0; i < 3; i++) expect_rq(0, h[i], "write behind a stalled endpoint");
        for (int i = 0; i < 2; i++) begin
            h[i] = make_hdr(DMA_READ, 64 + i);
            send_up(1, h[i]);
            expect_rq(1, h[i], "read ahead of stalled completions");
            c[i] = make_rc(i, 1'b1);
        end
        fork
            for (int i = 0; i < 2; i++) send_rc(c[i]);
            begin
                down_dst_rdy[1] = 1'b0;
                repeat (12) @(negedge clk);
                down_dst_rdy[1] = 1'b1;
            end
        join
        for (int i = 0; i < 2; i++) expect_cpl(c[i], "completion behind a stalled port");
        check_idle();
    endtask

    initial begin
        test_reads_writes();
        test_exhaustion();
        test_routing();
        test_round_robin();
        test_unexpected();
        test_backpressure();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: trans_ifs.sv
//--------------------------------------------------------------------------
// Internal channels of the controller core: decoded request channel
// from decode to execute, tag lookup and release channel from result
// to execute
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

// Decoded DMA request with the index of the port it came from
interface dec_req_if import pcie_trans_pkg::*; #(
    parameter int DMA_PORTS = 2
) ();

    localparam int PORT_W = (DMA_PORTS > 1) ? $clog2(DMA_PORTS) : 1;

    logic              src_rdy;
    logic              dst_rdy;
    up_hdr_t           hdr;
    logic [PORT_W-1:0] port;

    modport dec (output src_rdy, hdr, port, input dst_rdy);
    modport exe (input src_rdy, hdr, port, output dst_rdy);

endinterface

// Completion tag lookup, answered combinationally by the tag table
interface tag_lookup_if import pcie_trans_pkg::*; #(
    parameter int DMA_PORTS = 2
) ();

    localparam int PORT_W = (DMA_PORTS > 1) ? $clog2(DMA_PORTS) : 1;

    logic [TAG_W-1:0]  lookup_tag;
    logic              release_vld;
    logic [TAG_W-1:0]  release_tag;

    logic              hit;
    logic [PORT_W-1:0] owner_port;
    logic [TAG_W-1:0]  owner_dma_tag;

    modport res (
        output lookup_tag, release_vld, release_tag,
        input  hit, owner_port, owner_dma_tag
    );
    modport exe (
        input  lookup_tag, release_vld, release_tag,
        output hit, owner_port, owner_dma_tag
    );

endinterface

`default_nettype wire

// File: up_hdr_decode.sv
//--------------------------------------------------------------------------
// Upstream request decode: round-robin choice among the DMA ports and
// a single register slot holding the chosen header and its port index
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module up_hdr_decode import pcie_trans_pkg::*; #(
    parameter int DMA_PORTS = 2
) (
    input  wire logic                 clk,
    input  wire logic                 rst,

    input  wire logic [DMA_PORTS-1:0] up_src_rdy,
    input  wire up_hdr_t              up_hdr [DMA_PORTS],
    output logic [DMA_PORTS-1:0]      up_dst_rdy,

    dec_req_if.dec                    req
);

    localparam int PORT_W = (DMA_PORTS > 1) ? $clog2(DMA_PORTS) : 1;

    logic              slot_vld;
    up_hdr_t           slot_hdr;
    logic [PORT_W-1:0] slot_port;

    // First port searched in the next arbitration
    logic [PORT_W-1:0] rr_ptr;

    logic              found;
    logic [PORT_W-1:0] sel;
    logic              accept;
    logic              up_fire;

    // ----------------------------------------------------------------------
    // Round-robin search starting at rr_ptr
    // ----------------------------------------------------------------------
    always_comb begin
        int idx;
        found = 1'b0;
        sel   = '0;
        for (int i = 0; i < DMA_PORTS; i++) begin
            idx = int'(rr_ptr) + i;
            if (idx >= DMA_PORTS) begin
                idx = idx - DMA_PORTS;
            end
            if (!found && up_src_rdy[idx]) begin
                found = 1'b1;
                sel   = PORT_W'(idx);
            end
        end
    end

    // Slot is free or drains this cycle
    assign accept  = !slot_vld || req.dst_rdy;
    assign up_fire = found && accept;

    always_comb begin
        up_dst_rdy = '0;
        if (up_fire) begin
            up_dst_rdy[sel] = 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // Decode slot and pointer
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_vld <= 1'b0;
            rr_ptr   <= '0;
        end else if (up_fire) begin
            slot_vld <= 1'b1;
            if (int'(sel) == DMA_PORTS - 1) begin
                rr_ptr <= '0;
            end else begin
                rr_ptr <= sel + 1'b1;
            end
        end else if (req.dst_rdy) begin
            slot_vld <= 1'b0;
        end
    end

    // Header and port carry no reset
    always_ff @(posedge clk) begin
        if (up_fire) begin
            slot_hdr  <= up_hdr[sel];
            slot_port <= sel;
        end
    end

    assign req.src_rdy = slot_vld;
    assign req.hdr     = slot_hdr;
    assign req.port    = slot_port;

endmodule

`default_nettype wire
